// ==== write_buffer.f ====
src/wb_pkg.sv
src/wb_admit.sv
src/wb_slot.sv
src/wb_axi_issue.sv
src/write_buffer.sv
tests/wb_checker.sv
tests/tb_write_buffer.sv

// ==== Makefile ====
SRCS := $(wildcard src/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_write_buffer: write_buffer.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_write_buffer -f write_buffer.f

run: obj_dir/Vtb_write_buffer
	./obj_dir/Vtb_write_buffer > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_write_buffer.sv ====
`timescale 1ns/1ps

module tb_write_buffer;
    import wb_pkg::*;

    localparam int KIND_LINE     = 0;
    localparam int KIND_UNC      = 1;
    localparam int KIND_BOTH     = 2;
    localparam int KIND_PAUSE    = 3;
    localparam int KIND_RESUME   = 4;
    localparam int REQ_TIMEOUT   = 2000;
    localparam int DRAIN_TIMEOUT = 5000;
    localparam int NO_CHECK      = -1;

    // one stimulus row, check_ready holds the expected {line, unc} ready after the gap
    typedef struct {
        int    kind;
        addr_t line_addr;
        line_t line_data;
        addr_t unc_addr;
        word_t unc_data;
        strb_t strb;
        int    gap;
        int    check_ready;
    } row_t;

    logic       i_clk = 1'b0;
    logic       i_rst;
    logic       i_line_we;
    addr_t      i_line_addr;
    line_t      i_line_data;
    logic       o_line_ready;
    logic       i_unc_we;
    addr_t      i_unc_addr;
    word_t      i_unc_data;
    strb_t      i_unc_strb;
    logic       o_unc_ready;
    logic       o_idle;
    logic       o_awvalid;
    logic       i_awready = 1'b0;
    addr_t      o_awaddr;
    logic [7:0] o_awlen;
    logic [2:0] o_awsize;
    logic [1:0] o_awburst;
    logic       o_wvalid;
    logic       i_wready = 1'b0;
    word_t      o_wdata;
    strb_t      o_wstrb;
    logic       o_wlast;
    logic       i_bvalid = 1'b0;
    logic       o_bready;

    row_t table_rows [$];
    logic paused;
    logic r_paused = 1'b0;
    logic last_seen = 1'b0;
    logic b_seen = 1'b0;
    int   b_wait = 0;
    logic stuck;
    int   tb_errors;
    int   chk_errors;
    int   chk_completed;
    int   chk_pending;
    int   total;

    always #5 i_clk = ~i_clk;

    write_buffer i_write_buffer (.*);

    wb_checker u_checker (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_line_we    (i_line_we),
        .i_line_addr  (i_line_addr),
        .i_line_data  (i_line_data),
        .i_line_ready (o_line_ready),
        .i_unc_we     (i_unc_we),
        .i_unc_addr   (i_unc_addr),
        .i_unc_data   (i_unc_data),
        .i_unc_strb   (i_unc_strb),
        .i_unc_ready  (o_unc_ready),
        .i_idle       (o_idle),
        .i_awvalid    (o_awvalid),
        .i_awready    (i_awready),
        .i_awaddr     (o_awaddr),
        .i_awlen      (o_awlen),
        .i_awsize     (o_awsize),
        .i_awburst    (o_awburst),
        .i_wvalid     (o_wvalid),
        .i_wready     (i_wready),
        .i_wdata      (o_wdata),
        .i_wstrb      (o_wstrb),
        .i_wlast      (o_wlast),
        .i_bvalid     (i_bvalid),
        .i_bready     (o_bready),
        .o_errors     (chk_errors),
        .o_completed  (chk_completed),
        .o_pending    (chk_pending)
    );

    always @(posedge i_clk) begin
        r_paused  <= paused;
        last_seen <= o_wvalid && i_wready && o_wlast;
        b_seen    <= i_bvalid && o_bready;
    end

    // AXI slave, random AW and W stalls, B one to three cycles after wlast
    always @(negedge i_clk) begin
        if (i_rst) begin
            i_awready = 1'b0;
            i_wready  = 1'b0;
            i_bvalid  = 1'b0;
            b_wait    = 0;
        end else begin
            i_awready = !r_paused && (($urandom % 4) != 0);
            i_wready  = !r_paused && (($urandom % 4) != 0);
            if (b_seen) begin
                i_bvalid = 1'b0;
            end
            if (last_seen) begin
                b_wait = 1 + int'($urandom % 3);
            end else if (b_wait > 0 && !r_paused) begin
                b_wait--;
                if (b_wait == 0) begin
                    i_bvalid = 1'b1;
                end
            end
        end
    end

    function automatic line_t make_line(input word_t base);
        line_t l;
        for (int i = 0; i < LINE_WORDS; i++) begin
            l[i] = base + word_t'(i);
        end
        return l;
    endfunction

    task automatic add_row(input int kind, input addr_t la, input line_t ld, input addr_t ua,
                           input word_t ud, input strb_t st, input int gap, input int chk);
        row_t r;
        r.kind        = kind;
        r.line_addr   = la;
        r.line_data   = ld;
        r.unc_addr    = ua;
        r.unc_data    = ud;
        r.strb        = st;
        r.gap         = gap;
        r.check_ready = chk;
        table_rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(KIND_LINE, 32'h1000, make_line(32'ha000_0000), '0, '0, '0, 30, NO_CHECK);
        add_row(KIND_UNC, '0, '0, 32'h2004, 32'hdead_beef, 4'b0011, 30, NO_CHECK);
        add_row(KIND_BOTH, 32'h1010, make_line(32'hb000_0000), 32'h3008, 32'hcafe_f00d,
                4'b1100, 10, NO_CHECK);
        // fill every slot while the slave is stalled
        add_row(KIND_PAUSE, '0, '0, '0, '0, '0, 2, 2'b11);
        for (int n = 0; n < 6; n++) begin
            add_row(KIND_LINE, addr_t'(32'h4000 + n * 16), make_line(word_t'(32'hc000_0000 + n * 256)),
                    '0, '0, '0, 0, NO_CHECK);
        end
        add_row(KIND_UNC, '0, '0, 32'h5000, 32'h0102_0304, 4'b1111, 0, 2'b10);
        add_row(KIND_LINE, 32'h4060, make_line(32'hd000_0000), '0, '0, '0, 3, 2'b00);
        add_row(KIND_RESUME, '0, '0, '0, '0, '0, 0, NO_CHECK);
        for (int n = 0; n < 16; n++) begin
            add_row(int'($urandom % 3), $urandom & 32'hffff_fff0, make_line($urandom),
                    $urandom & 32'hffff_fffc, $urandom, strb_t'($urandom % 15 + 1),
                    int'($urandom % 3), NO_CHECK);
        end
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        tb_errors++;
    endtask

    // holds each write enable until its own accept, starts and ends on a falling edge
    task automatic drive_request(input logic do_line, input logic do_unc);
        logic line_pend;
        logic unc_pend;
        logic line_acc;
        logic unc_acc;
        int   waited;
        line_pend = do_line;
        unc_pend  = do_unc;
        waited    = 0;
        while ((line_pend || unc_pend) && waited < REQ_TIMEOUT) begin
            i_line_we = line_pend;
            i_unc_we  = unc_pend;
            line_acc  = line_pend && o_line_ready;
            unc_acc   = unc_pend && o_unc_ready;
            @(negedge i_clk);
            if (line_acc) begin
                line_pend = 1'b0;
            end
            if (unc_acc) begin
                unc_pend = 1'b0;
            end
            waited++;
        end
        i_line_we = 1'b0;
        i_unc_we  = 1'b0;
        if (line_pend || unc_pend) begin
            $display("timeout at %0t: a write was never accepted", $time);
            tb_errors++;
            stuck = 1'b1;
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!o_idle && waited < DRAIN_TIMEOUT) begin
            @(negedge i_clk);
            waited++;
        end
        if (!o_idle) begin
            $display("timeout at %0t: the buffer never drained to idle", $time);
            tb_errors++;
            stuck = 1'b1;
        end
    endtask

    task automatic apply_row(input row_t r);
        i_line_addr = r.line_addr;
        i_line_data = r.line_data;
        i_unc_addr  = r.unc_addr;
        i_unc_data  = r.unc_data;
        i_unc_strb  = r.strb;
        case (r.kind)
            KIND_LINE:   drive_request(1'b1, 1'b0);
            KIND_UNC:    drive_request(1'b0, 1'b1);
            KIND_BOTH:   drive_request(1'b1, 1'b1);
            KIND_PAUSE: begin
                wait_idle();
                paused = 1'b1;
            end
            default:     paused = 1'b0;
        endcase
        repeat (r.gap) @(negedge i_clk);
        if (r.check_ready != NO_CHECK && {o_line_ready, o_unc_ready} !== r.check_ready[1:0]) begin
            report_mismatch($sformatf("ready {line,unc} %b%b, expected %b", o_line_ready,
                                      o_unc_ready, r.check_ready[1:0]));
        end
    endtask

    task automatic check_reset_state();
        if (o_awvalid !== 1'b0 || o_wvalid !== 1'b0 || o_wlast !== 1'b0 || o_bready !== 1'b0) begin
            report_mismatch("AXI valid, wlast or bready not low after reset");
        end
        if (o_line_ready !== 1'b1 || o_unc_ready !== 1'b1 || o_idle !== 1'b1) begin
            report_mismatch("ready or idle not high after reset");
        end
    endtask

    initial begin
        void'($urandom(32'h3bff));
        i_rst       = 1'b1;
        i_line_we   = 1'b0;
        i_line_addr = '0;
        i_line_data = '0;
        i_unc_we    = 1'b0;
        i_unc_addr  = '0;
        i_unc_data  = '0;
        i_unc_strb  = '0;
        paused      = 1'b0;
        stuck       = 1'b0;
        tb_errors   = 0;
        build_table();
        repeat (8) @(negedge i_clk);
        i_rst = 1'b0;
        check_reset_state();
        for (int n = 0; n < table_rows.size() && !stuck; n++) begin
            apply_row(table_rows[n]);
        end
        if (!stuck) begin
            wait_idle();
        end
        repeat (20) @(negedge i_clk);  // quiet bus, no stray AW
        if (!stuck && chk_pending != 0) begin
            $display("error: %0d accepted writes never left the buffer", chk_pending);
            tb_errors++;
        end
        total = tb_errors + chk_errors;
        $display("%0d writes completed, %0d errors", chk_completed, total);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tests/wb_checker.sv ====
`timescale 1ns/1ps

module wb_checker (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_line_we,
    input  wb_pkg::addr_t i_line_addr,
    input  wb_pkg::line_t i_line_data,
    input  logic          i_line_ready,
    input  logic          i_unc_we,
    input  wb_pkg::addr_t i_unc_addr,
    input  wb_pkg::word_t i_unc_data,
    input  wb_pkg::strb_t i_unc_strb,
    input  logic          i_unc_ready,
    input  logic          i_idle,
    input  logic          i_awvalid,
    input  logic          i_awready,
    input  wb_pkg::addr_t i_awaddr,
    input  logic [7:0]    i_awlen,
    input  logic [2:0]    i_awsize,
    input  logic [1:0]    i_awburst,
    input  logic          i_wvalid,
    input  logic          i_wready,
    input  wb_pkg::word_t i_wdata,
    input  wb_pkg::strb_t i_wstrb,
    input  logic          i_wlast,
    input  logic          i_bvalid,
    input  logic          i_bready,
    output int            o_errors,
    output int            o_completed,
    output int            o_pending
);
    import wb_pkg::*;

    // expected bursts in acceptance order
    addr_t      exp_addr [$];
    logic [7:0] exp_len  [$];
    strb_t      exp_strb [$];
    line_t      exp_data [$];

    int    outstanding = 0;  // slots held, from accepts and B responses
    int    beat = 0;
    int    errors = 0;
    int    completed = 0;
    int    pending = 0;
    logic  aw_seen = 1'b0;
    logic  burst_bad = 1'b0;
    line_t unc_line;
    word_t want_word;

    assign o_errors    = errors;
    assign o_completed = completed;
    assign o_pending   = pending;

    task automatic flag_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
        burst_bad = 1'b1;
    endtask

    task automatic report_problem(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic expect_write(input addr_t addr, input logic [7:0] len,
                                input strb_t strb, input line_t data);
        exp_addr.push_back(addr);
        exp_len.push_back(len);
        exp_strb.push_back(strb);
        exp_data.push_back(data);
    endtask

    task automatic check_aw();
        if (exp_addr.size() == 0) begin
            report_problem("an AW burst appeared with no accepted write waiting");
        end else begin
            if (aw_seen) begin
                report_problem("a second AW came before the B response");
            end
            if (i_awaddr !== exp_addr[0]) begin
                flag_error($sformatf("awaddr %h, expected %h", i_awaddr, exp_addr[0]));
            end
            if (i_awlen !== exp_len[0]) begin
                flag_error($sformatf("awlen %0d, expected %0d", i_awlen, exp_len[0]));
            end
            if (i_awsize !== 3'b010) begin
                flag_error($sformatf("awsize %b, expected 010", i_awsize));
            end
            if (i_awburst !== 2'b01) begin
                flag_error($sformatf("awburst %b, expected INCR", i_awburst));
            end
        end
        aw_seen = 1'b1;
        beat    = 0;
    endtask

    task automatic check_w();
        if (!aw_seen || exp_addr.size() == 0) begin
            report_problem("a W beat came without an address phase");
        end else if (beat > int'(exp_len[0])) begin
            report_problem("a W beat came past the burst length");
        end else begin
            want_word = exp_data[0][beat];
            if (i_wdata !== want_word) begin
                flag_error($sformatf("beat %0d wdata %h, expected %h", beat, i_wdata, want_word));
            end
            if (i_wstrb !== exp_strb[0]) begin
                flag_error($sformatf("beat %0d wstrb %b, expected %b", beat, i_wstrb, exp_strb[0]));
            end
            if (i_wlast !== (beat == int'(exp_len[0]))) begin
                flag_error($sformatf("beat %0d wlast %b", beat, i_wlast));
            end
        end
        beat++;
    endtask

    task automatic finish_write();
        if (!aw_seen || exp_addr.size() == 0) begin
            report_problem("a B response came without a burst");
        end else begin
            if (beat != int'(exp_len[0]) + 1) begin
                flag_error($sformatf("B after %0d beats, expected %0d", beat, exp_len[0] + 1));
            end
            $display("write %0d to %h, %0d beat(s): %s", completed, exp_addr[0],
                     int'(exp_len[0]) + 1, burst_bad ? "mismatch" : "ok");
            void'(exp_addr.pop_front());
            void'(exp_len.pop_front());
            void'(exp_strb.pop_front());
            void'(exp_data.pop_front());
            completed++;
        end
        aw_seen   = 1'b0;
        burst_bad = 1'b0;
    endtask

    always @(posedge i_clk) begin
        if (i_rst) begin
            outstanding = 0;
            aw_seen     = 1'b0;
            burst_bad   = 1'b0;
            beat        = 0;
            exp_addr.delete();
            exp_len.delete();
            exp_strb.delete();
            exp_data.delete();
        end else begin
            // ready and idle follow the number of slots in use
            if (i_line_ready !== (outstanding < NUM_SLOTS)) begin
                flag_error($sformatf("line ready %b with %0d slots used", i_line_ready, outstanding));
            end
            if (i_unc_ready !== (outstanding <= NUM_SLOTS - 2)) begin
                flag_error($sformatf("unc ready %b with %0d slots used", i_unc_ready, outstanding));
            end
            if (i_idle !== (outstanding == 0)) begin
                flag_error($sformatf("idle %b with %0d slots used", i_idle, outstanding));
            end
            // bready only once every beat of the burst is through
            if (i_bready && !(aw_seen && exp_addr.size() != 0 && beat > int'(exp_len[0]))) begin
                report_problem("bready high with no burst waiting for its response");
            end
            if (i_line_we && i_line_ready) begin  // line queued ahead of a same-cycle store
                expect_write(i_line_addr, LINE_LEN, 4'hf, i_line_data);
                outstanding++;
            end
            if (i_unc_we && i_unc_ready) begin
                unc_line    = '0;
                unc_line[0] = i_unc_data;
                expect_write(i_unc_addr, 8'd0, i_unc_strb, unc_line);
                outstanding++;
            end
            if (i_awvalid && i_awready) begin
                check_aw();
            end
            if (i_wvalid && i_wready) begin
                check_w();
            end
            if (i_bvalid && i_bready) begin
                finish_write();
                outstanding--;
            end
        end
        pending = exp_addr.size();
    end

endmodule

// ==== src/write_buffer.sv ====
`timescale 1ns/1ps

module write_buffer (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_line_we,
    input  wb_pkg::addr_t    i_line_addr,
    input  wb_pkg::line_t    i_line_data,
    output logic             o_line_ready,
    input  logic             i_unc_we,
    input  wb_pkg::addr_t    i_unc_addr,
    input  wb_pkg::word_t    i_unc_data,
    input  wb_pkg::strb_t    i_unc_strb,
    output logic             o_unc_ready,
    output logic             o_idle,
    output logic             o_awvalid,
    input  logic             i_awready,
    output wb_pkg::addr_t    o_awaddr,
    output wb_pkg::beat_t    o_awlen,
    output logic [2:0]       o_awsize,
    output logic [1:0]       o_awburst,
    output logic             o_wvalid,
    input  logic             i_wready,
    output wb_pkg::word_t    o_wdata,
    output wb_pkg::strb_t    o_wstrb,
    output logic             o_wlast,
    input  logic             i_bvalid,
    output logic             o_bready
);
    import wb_pkg::*;

    slot_mask_t              load;
    addr_t [NUM_SLOTS-1:0]   load_addr;
    beat_t [NUM_SLOTS-1:0]   load_len;
    strb_t [NUM_SLOTS-1:0]   load_strb;
    addr_t [NUM_SLOTS-1:0]   slot_addr;
    beat_t [NUM_SLOTS-1:0]   slot_len;
    strb_t [NUM_SLOTS-1:0]   slot_strb;
    word_t [NUM_SLOTS-1:0]   slot_word;
    slot_id_t                head;
    logic                    head_valid;
    logic                    pop;
    slot_id_t                pop_slot;
    beat_t                   beat;      // broadcast word select

    wb_admit u_admit (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_line_we    (i_line_we),
        .i_line_addr  (i_line_addr),
        .i_unc_we     (i_unc_we),
        .i_unc_addr   (i_unc_addr),
        .i_unc_strb   (i_unc_strb),
        .i_pop        (pop),
        .i_pop_slot   (pop_slot),
        .o_line_ready (o_line_ready),
        .o_unc_ready  (o_unc_ready),
        .o_load       (load),
        .o_load_addr  (load_addr),
        .o_load_len   (load_len),
        .o_load_strb  (load_strb),
        .o_head       (head),
        .o_head_valid (head_valid),
        .o_idle       (o_idle)
    );

    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
        wb_slot u_slot (
            .i_clk      (i_clk),
            .i_rst      (i_rst),
            .i_load     (load[g]),
            .i_addr     (load_addr[g]),
            .i_len      (load_len[g]),
            .i_strb     (load_strb[g]),
            .i_line     (i_line_data),
            .i_unc_data (i_unc_data),
            .i_beat     (beat),
            .o_addr     (slot_addr[g]),
            .o_len      (slot_len[g]),
            .o_strb     (slot_strb[g]),
            .o_word     (slot_word[g])
        );
    end

    wb_axi_issue u_issue (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_head       (head),
        .i_head_valid (head_valid),
        .i_slot_addr  (slot_addr),
        .i_slot_len   (slot_len),
        .i_slot_strb  (slot_strb),
        .i_slot_word  (slot_word),
        .i_awready    (i_awready),
        .i_wready     (i_wready),
        .i_bvalid     (i_bvalid),
        .o_beat       (beat),
        .o_pop        (pop),
        .o_pop_slot   (pop_slot),
        .o_awvalid    (o_awvalid),
        .o_awaddr     (o_awaddr),
        .o_awlen      (o_awlen),
        .o_awsize     (o_awsize),
        .o_awburst    (o_awburst),
        .o_wvalid     (o_wvalid),
        .o_wdata      (o_wdata),
        .o_wstrb      (o_wstrb),
        .o_wlast      (o_wlast),
        .o_bready     (o_bready)
    );

endmodule

// ==== src/wb_axi_issue.sv ====
`timescale 1ns/1ps

module wb_axi_issue (
    input  logic                                  i_clk,
    input  logic                                  i_rst,
    input  wb_pkg::slot_id_t                      i_head,
    input  logic                                  i_head_valid,
    input  wb_pkg::addr_t [wb_pkg::NUM_SLOTS-1:0] i_slot_addr,
    input  wb_pkg::beat_t [wb_pkg::NUM_SLOTS-1:0] i_slot_len,
    input  wb_pkg::strb_t [wb_pkg::NUM_SLOTS-1:0] i_slot_strb,
    input  wb_pkg::word_t [wb_pkg::NUM_SLOTS-1:0] i_slot_word,
    input  logic                                  i_awready,
    input  logic                                  i_wready,
    input  logic                                  i_bvalid,
    output wb_pkg::beat_t                         o_beat,
    output logic                                  o_pop,
    output wb_pkg::slot_id_t                      o_pop_slot,
    output logic                                  o_awvalid,
    output wb_pkg::addr_t                         o_awaddr,
    output wb_pkg::beat_t                         o_awlen,
    output logic [2:0]                            o_awsize,
    output logic [1:0]                            o_awburst,
    output logic                                  o_wvalid,
    output wb_pkg::word_t                         o_wdata,
    output wb_pkg::strb_t                         o_wstrb,
    output logic                                  o_wlast,
    output logic                                  o_bready
);
    import wb_pkg::*;

    issue_state_t r_state;
    issue_state_t w_state_next;
    slot_id_t     r_slot;        // slot being drained
    beat_t        r_beat;
    logic         w_last_beat;

    assign w_last_beat = r_beat == i_slot_len[r_slot];

    always_comb begin
        w_state_next = r_state;
        case (r_state)
            ST_IDLE: begin
                if (i_head_valid) begin
                    w_state_next = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (i_awready) begin
                    w_state_next = ST_DATA;
                end
            end
            ST_DATA: begin
                if (i_wready && w_last_beat) begin
                    w_state_next = ST_RESP;
                end
            end
            ST_RESP: begin
                if (i_bvalid) begin
                    w_state_next = ST_IDLE;  // slot freed on this edge
                end
            end
            default: w_state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state <= ST_IDLE;
            r_beat  <= '0;
        end else begin
            r_state <= w_state_next;
            if (r_state == ST_IDLE) begin
                r_beat <= '0;
            end else if (o_wvalid && i_wready && !w_last_beat) begin
                r_beat <= r_beat + beat_t'(1);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_state == ST_IDLE && i_head_valid) begin
            r_slot <= i_head;
        end
    end

    // AW channel
    assign o_awvalid = r_state == ST_ADDR;
    assign o_awaddr  = i_slot_addr[r_slot];
    assign o_awlen   = i_slot_len[r_slot];
    assign o_awsize  = SIZE_WORD;
    assign o_awburst = BURST_INCR;

    // W channel
    assign o_wvalid = r_state == ST_DATA;
    assign o_wdata  = i_slot_word[r_slot];
    assign o_wstrb  = i_slot_strb[r_slot];
    assign o_wlast  = o_wvalid && w_last_beat;
    assign o_beat   = r_beat;

    // B channel
    assign o_bready   = r_state == ST_RESP;
    assign o_pop      = o_bready && i_bvalid;
    assign o_pop_slot = r_slot;

    a_aw_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr) && $stable(o_awlen));

    // slot contents must not change under a stalled beat
    a_w_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_wvalid && !i_wready |=> o_wvalid && $stable(o_wdata) && $stable(o_wlast));

endmodule

// ==== src/wb_slot.sv ====
`timescale 1ns/1ps

module wb_slot (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_load,
    input  wb_pkg::addr_t i_addr,
    input  wb_pkg::beat_t i_len,
    input  wb_pkg::strb_t i_strb,
    input  wb_pkg::line_t i_line,
    input  wb_pkg::word_t i_unc_data,
    input  wb_pkg::beat_t i_beat,
    output wb_pkg::addr_t o_addr,
    output wb_pkg::beat_t o_len,
    output wb_pkg::strb_t o_strb,
    output wb_pkg::word_t o_word
);
    import wb_pkg::*;

    addr_t r_addr;
    beat_t r_len;
    strb_t r_strb;
    line_t r_line;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_len <= '0;
        end else if (i_load) begin
            r_len <= i_len;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            r_addr <= i_addr;
            r_strb <= i_strb;
            if (i_len == '0) begin
                r_line[0] <= i_unc_data;  // single store sits in word 0
            end else begin
                r_line <= i_line;
            end
        end
    end

    assign o_addr = r_addr;
    assign o_len  = r_len;
    assign o_strb = r_strb;
    assign o_word = r_line[i_beat[WORD_SEL_BITS-1:0]];  // beat picks the word

    // beat counter from the issue engine never runs past a line
    a_beat_in_line: assert property (@(posedge i_clk) disable iff (i_rst)
        i_beat <= LINE_LEN);

endmodule

// ==== src/wb_admit.sv ====
`timescale 1ns/1ps

module wb_admit (
    input  logic                                  i_clk,
    input  logic                                  i_rst,
    input  logic                                  i_line_we,
    input  wb_pkg::addr_t                         i_line_addr,
    input  logic                                  i_unc_we,
    input  wb_pkg::addr_t                         i_unc_addr,
    input  wb_pkg::strb_t                         i_unc_strb,
    input  logic                                  i_pop,
    input  wb_pkg::slot_id_t                      i_pop_slot,
    output logic                                  o_line_ready,
    output logic                                  o_unc_ready,
    output wb_pkg::slot_mask_t                    o_load,
    output wb_pkg::addr_t [wb_pkg::NUM_SLOTS-1:0] o_load_addr,
    output wb_pkg::beat_t [wb_pkg::NUM_SLOTS-1:0] o_load_len,
    output wb_pkg::strb_t [wb_pkg::NUM_SLOTS-1:0] o_load_strb,
    output wb_pkg::slot_id_t                      o_head,
    output logic                                  o_head_valid,
    output logic                                  o_idle
);
    import wb_pkg::*;

    // lowest set bit of the mask
    function automatic slot_id_t first_free(input slot_mask_t mask);
        slot_id_t id;
        id = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                id = slot_id_t'(i);
            end
        end
        return id;
    endfunction

    slot_mask_t         r_free;              // 1 = slot free
    slot_id_t           r_queue [NUM_SLOTS]; // arrival order of slot ids
    slot_id_t           r_wr_ptr;
    slot_id_t           r_rd_ptr;
    logic [SLOT_BITS:0] r_count;

    slot_id_t           w_first;
    slot_id_t           w_second;
    slot_id_t           w_unc_slot;
    slot_id_t           w_unc_pos;
    slot_mask_t         w_rest;
    slot_mask_t         w_load_line;
    slot_mask_t         w_load_unc;
    slot_mask_t         w_freed;
    logic               w_line_acc;
    logic               w_unc_acc;
    logic [SLOT_BITS:0] w_push_n;

    assign w_first  = first_free(r_free);
    assign w_rest   = r_free & ~(slot_mask_t'(1) << w_first);
    assign w_second = first_free(w_rest);

    assign o_line_ready = |r_free;
    assign o_unc_ready  = |w_rest;  // store leaves one slot for a writeback

    assign w_line_acc = i_line_we && o_line_ready;
    assign w_unc_acc  = i_unc_we && o_unc_ready;

    // line takes the first free slot when both arrive together
    assign w_unc_slot = w_line_acc ? w_second : w_first;

    assign w_load_line = w_line_acc ? (slot_mask_t'(1) << w_first) : '0;
    assign w_load_unc  = w_unc_acc ? (slot_mask_t'(1) << w_unc_slot) : '0;
    assign w_freed     = i_pop ? (slot_mask_t'(1) << i_pop_slot) : '0;
    assign o_load      = w_load_line | w_load_unc;

    // per slot fields, only looked at where the load bit is set
    for (genvar k = 0; k < NUM_SLOTS; k++) begin : g_field
        assign o_load_addr[k] = w_load_unc[k] ? i_unc_addr : i_line_addr;
        assign o_load_len[k]  = w_load_unc[k] ? beat_t'(0) : LINE_LEN;
        assign o_load_strb[k] = w_load_unc[k] ? i_unc_strb : '1;
    end

    assign w_push_n  = {{SLOT_BITS{1'b0}}, w_line_acc} + {{SLOT_BITS{1'b0}}, w_unc_acc};
    assign w_unc_pos = r_wr_ptr + slot_id_t'(w_line_acc);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_free   <= '1;
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            r_free   <= (r_free & ~o_load) | w_freed;
            r_wr_ptr <= r_wr_ptr + slot_id_t'(w_push_n);
            if (i_pop) begin
                r_rd_ptr <= r_rd_ptr + slot_id_t'(1);
            end
            r_count <= r_count + w_push_n - {{SLOT_BITS{1'b0}}, i_pop};
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_line_acc) begin
            r_queue[r_wr_ptr] <= w_first;
        end
        if (w_unc_acc) begin
            r_queue[w_unc_pos] <= w_unc_slot;  // right behind the line
        end
    end

    assign o_head       = r_queue[r_rd_ptr];
    assign o_head_valid = r_count != '0;
    assign o_idle       = &r_free;

    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
        (w_line_acc || w_unc_acc) |-> (r_count + w_push_n) <= NUM_SLOTS);

    // a pop must name a slot that is really in use
    a_no_underflow: assert property (@(posedge i_clk) disable iff (i_rst)
        i_pop |-> (r_count != '0) && !r_free[i_pop_slot]);

    a_line_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        i_line_we |-> i_line_addr[LINE_OFFSET-1:0] == '0);

endmodule

// ==== src/wb_pkg.sv ====
package wb_pkg;

    localparam int LINE_WORDS    = 4;
    localparam int NUM_SLOTS     = 8;
    localparam int SLOT_BITS     = $clog2(NUM_SLOTS);
    localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);  // word index inside a line
    localparam int LINE_OFFSET   = WORD_SEL_BITS + 2;   // byte offset bits of a line

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;
    typedef word_t [LINE_WORDS-1:0] line_t;

    // AXI awlen width, also used as beat counter
    typedef logic [7:0] beat_t;

    typedef logic [SLOT_BITS-1:0] slot_id_t;
    typedef logic [NUM_SLOTS-1:0] slot_mask_t;

    localparam beat_t      LINE_LEN   = beat_t'(LINE_WORDS - 1);
    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [2:0] SIZE_WORD  = 3'b010;  // 4 bytes per beat

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } issue_state_t;

endpackage
